//--- hw/dmiss_pkg.sv
`default_nettype none

package dmiss_pkg;

  // cache-line physical address without the byte offset
  localparam int LINE_ADDR_W = 37;

  localparam int MAX_ENTRIES = 16;  // upper bound on miss entries
  localparam int TAG_W = $clog2(MAX_ENTRIES);  // entry index on the memory side

  typedef enum logic {
    MISS_LOAD  = 1'b0,
    MISS_STORE = 1'b1
  } miss_op_t;

  typedef enum logic [1:0] {
    ENT_FREE    = 2'd0,
    ENT_PENDING = 2'd1,  // claimed but not yet requested
    ENT_ISSUED  = 2'd2,  // request sent to memory
    ENT_DONE    = 2'd3   // response back and waiting for replay
  } entry_state_t;

endpackage

`default_nettype wire

//--- hw/miss_entry.sv
`timescale 1ns/1ps
`default_nettype none

module miss_entry (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire                                   claim_i,
  input  wire                                   merge_i,
  input  wire  [dmiss_pkg::LINE_ADDR_W-1:0]     addr_i,
  input  wire  dmiss_pkg::miss_op_t             op_i,
  input  wire                                   issue_i,
  input  wire                                   done_i,
  input  wire                                   free_all_i,
  output dmiss_pkg::entry_state_t               state_o,
  output logic [dmiss_pkg::LINE_ADDR_W-1:0]     addr_o,
  output dmiss_pkg::miss_op_t                   op_o,
  output logic                                  match_o
);

  dmiss_pkg::entry_state_t              state_q;
  logic [dmiss_pkg::LINE_ADDR_W-1:0]    addr_q;
  dmiss_pkg::miss_op_t                  op_q;
  logic                                 store_merge;

  assign store_merge = merge_i && (op_i == dmiss_pkg::MISS_STORE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= dmiss_pkg::ENT_FREE;
    end else if (free_all_i) begin
      state_q <= dmiss_pkg::ENT_FREE;  // replay releases everything
    end else if (claim_i) begin
      state_q <= dmiss_pkg::ENT_PENDING;
    end else if (issue_i && state_q == dmiss_pkg::ENT_PENDING) begin
      state_q <= dmiss_pkg::ENT_ISSUED;
    end else if (done_i && state_q == dmiss_pkg::ENT_ISSUED) begin
      state_q <= dmiss_pkg::ENT_DONE;
    end
  end

  always_ff @(posedge clk) begin
    if (claim_i) begin
      addr_q <= addr_i;
      op_q   <= op_i;
    end else if (store_merge) begin
      op_q   <= dmiss_pkg::MISS_STORE;  // upgrade only
    end
  end

  assign state_o = state_q;
  assign addr_o  = addr_q;

  // a store merging in the same cycle the sequencer samples the entry
  // must already show up as a store in the request
  assign op_o    = store_merge ? dmiss_pkg::MISS_STORE : op_q;

  assign match_o = (state_q != dmiss_pkg::ENT_FREE) && (addr_q == addr_i);

endmodule

`default_nettype wire

//--- hw/miss_cam.sv
`timescale 1ns/1ps
`default_nettype none

module miss_cam #(
  parameter int NUM_ENTRIES = dmiss_pkg::MAX_ENTRIES
) (
  input  wire                                               clk,
  input  wire                                               rst,
  input  wire                                               alloc_valid_i,
  output logic                                              alloc_ready_o,
  input  wire  [dmiss_pkg::LINE_ADDR_W-1:0]                 alloc_addr_i,
  input  wire  dmiss_pkg::miss_op_t                         alloc_op_i,
  input  wire                                               issue_en_i,
  input  wire  [dmiss_pkg::TAG_W-1:0]                       issue_tag_i,
  input  wire                                               done_en_i,
  input  wire  [dmiss_pkg::TAG_W-1:0]                       done_tag_i,
  output logic [NUM_ENTRIES-1:0]                            pending_vec_o,
  output logic [NUM_ENTRIES-1:0]                            issued_vec_o,
  output logic [NUM_ENTRIES-1:0][dmiss_pkg::LINE_ADDR_W-1:0] entry_addr_o,
  output dmiss_pkg::miss_op_t [NUM_ENTRIES-1:0]             entry_op_o,
  output logic                                              locked_o,
  output logic                                              replay_o
);

  dmiss_pkg::entry_state_t          ent_state [NUM_ENTRIES];
  logic [NUM_ENTRIES-1:0]           match_vec;
  logic [NUM_ENTRIES-1:0]           free_vec;
  logic [NUM_ENTRIES-1:0]           claim_vec;
  logic [NUM_ENTRIES-1:0]           merge_vec;
  logic [NUM_ENTRIES-1:0]           issue_vec;
  logic [NUM_ENTRIES-1:0]           done_vec;
  logic [dmiss_pkg::TAG_W-1:0]      free_idx;
  logic                             free_found;
  logic                             last_free;
  logic                             merge_hit;
  logic                             alloc_fire;
  logic                             claim;
  logic                             started_q;
  logic                             locked_q;

  for (genvar k = 0; k < NUM_ENTRIES; k++) begin : g_entry
    assign free_vec[k]      = ent_state[k] == dmiss_pkg::ENT_FREE;
    assign pending_vec_o[k] = ent_state[k] == dmiss_pkg::ENT_PENDING;
    assign issued_vec_o[k]  = ent_state[k] == dmiss_pkg::ENT_ISSUED;
    assign claim_vec[k]     = claim && (free_idx == dmiss_pkg::TAG_W'(k));
    assign merge_vec[k]     = alloc_fire && match_vec[k];
    assign issue_vec[k]     = issue_en_i && (issue_tag_i == dmiss_pkg::TAG_W'(k));
    assign done_vec[k]      = done_en_i && (done_tag_i == dmiss_pkg::TAG_W'(k));

    miss_entry u_entry (
      .clk        (clk),
      .rst        (rst),
      .claim_i    (claim_vec[k]),
      .merge_i    (merge_vec[k]),
      .addr_i     (alloc_addr_i),
      .op_i       (alloc_op_i),
      .issue_i    (issue_vec[k]),
      .done_i     (done_vec[k]),
      .free_all_i (replay_o),
      .state_o    (ent_state[k]),
      .addr_o     (entry_addr_o[k]),
      .op_o       (entry_op_o[k]),
      .match_o    (match_vec[k])
    );
  end

  // lowest free entry wins
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int k = NUM_ENTRIES - 1; k >= 0; k--) begin
      if (free_vec[k]) begin
        free_found = 1'b1;
        free_idx   = dmiss_pkg::TAG_W'(k);
      end
    end
  end

  assign last_free = free_found && ((free_vec & (free_vec - 1'b1)) == '0);  // one bit set

  assign merge_hit     = |match_vec;
  assign alloc_ready_o = !locked_q && !replay_o;
  assign alloc_fire    = alloc_valid_i && alloc_ready_o;
  assign claim         = alloc_fire && !merge_hit && free_found;

  // epoch ends once every claimed line has come back
  assign replay_o = started_q && !(|(pending_vec_o | issued_vec_o));
  assign locked_o = locked_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      started_q <= 1'b0;
      locked_q  <= 1'b0;
    end else if (replay_o) begin
      started_q <= 1'b0;
      locked_q  <= 1'b0;
    end else begin
      if (claim) begin
        started_q <= 1'b1;
      end
      if (claim && last_free) begin
        locked_q <= 1'b1;  // entries exhausted
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/miss_intake.sv
`timescale 1ns/1ps
`default_nettype none

module miss_intake (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                miss_valid_i,
  output logic                               miss_ready_o,
  input  wire  [dmiss_pkg::LINE_ADDR_W-1:0]  miss_addr_i,
  input  wire  dmiss_pkg::miss_op_t          miss_op_i,
  output logic                               alloc_valid_o,
  input  wire                                alloc_ready_i,
  output logic [dmiss_pkg::LINE_ADDR_W-1:0]  alloc_addr_o,
  output dmiss_pkg::miss_op_t                alloc_op_o
);

  logic                               slot_valid_q;
  logic [dmiss_pkg::LINE_ADDR_W-1:0]  slot_addr_q;
  dmiss_pkg::miss_op_t                slot_op_q;
  logic                               take;
  logic                               drain;

  assign drain        = slot_valid_q && alloc_ready_i;
  assign miss_ready_o = !slot_valid_q || alloc_ready_i;  // empty or emptying
  assign take         = miss_valid_i && miss_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_valid_q <= 1'b0;
    end else if (take) begin
      slot_valid_q <= 1'b1;
    end else if (drain) begin
      slot_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      slot_addr_q <= miss_addr_i;
      slot_op_q   <= miss_op_i;
    end
  end

  assign alloc_valid_o = slot_valid_q;
  assign alloc_addr_o  = slot_addr_q;
  assign alloc_op_o    = slot_op_q;

endmodule

`default_nettype wire

//--- hw/refill_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module refill_sequencer #(
  parameter int NUM_ENTRIES = dmiss_pkg::MAX_ENTRIES
) (
  input  wire                                                clk,
  input  wire                                                rst,
  input  wire  [NUM_ENTRIES-1:0]                             pending_vec_i,
  input  wire  [NUM_ENTRIES-1:0][dmiss_pkg::LINE_ADDR_W-1:0] entry_addr_i,
  input  wire  dmiss_pkg::miss_op_t [NUM_ENTRIES-1:0]        entry_op_i,
  output logic                                               issue_en_o,
  output logic [dmiss_pkg::TAG_W-1:0]                        issue_tag_o,
  output logic                                               done_en_o,
  output logic [dmiss_pkg::TAG_W-1:0]                        done_tag_o,
  output logic                                               mem_req_valid_o,
  input  wire                                                mem_req_ready_i,
  output logic [dmiss_pkg::LINE_ADDR_W-1:0]                  mem_req_addr_o,
  output dmiss_pkg::miss_op_t                                mem_req_op_o,
  output logic [dmiss_pkg::TAG_W-1:0]                        mem_req_tag_o,
  input  wire                                                mem_rsp_valid_i,
  input  wire  [dmiss_pkg::TAG_W-1:0]                        mem_rsp_tag_i
);

  logic                          pick_found;
  logic [dmiss_pkg::TAG_W-1:0]   pick_idx;
  logic                          req_valid_q;
  logic                          load_ok;

  always_comb begin
    pick_found = 1'b0;
    pick_idx   = '0;
    for (int k = NUM_ENTRIES - 1; k >= 0; k--) begin
      if (pending_vec_i[k]) begin
        pick_found = 1'b1;
        pick_idx   = dmiss_pkg::TAG_W'(k);
      end
    end
  end

  // register empty or handing off this cycle
  assign load_ok     = !req_valid_q || mem_req_ready_i;
  assign issue_en_o  = load_ok && pick_found;
  assign issue_tag_o = pick_idx;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid_q <= 1'b0;
    end else if (issue_en_o) begin
      req_valid_q <= 1'b1;
    end else if (mem_req_ready_i) begin
      req_valid_q <= 1'b0;
    end
  end

  // held unchanged while memory stalls
  always_ff @(posedge clk) begin
    if (issue_en_o) begin
      mem_req_addr_o <= entry_addr_i[pick_idx];
      mem_req_op_o   <= entry_op_i[pick_idx];
      mem_req_tag_o  <= pick_idx;
    end
  end

  assign mem_req_valid_o = req_valid_q;

  // tag picks the entry since responses return in any order
  assign done_en_o  = mem_rsp_valid_i;
  assign done_tag_o = mem_rsp_tag_i;

endmodule

`default_nettype wire

//--- hw/dmiss_top.sv
`timescale 1ns/1ps
`default_nettype none

module dmiss_top #(
  parameter int NUM_ENTRIES = dmiss_pkg::MAX_ENTRIES
) (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                miss_valid_i,
  output logic                               miss_ready_o,
  input  wire  [dmiss_pkg::LINE_ADDR_W-1:0]  miss_addr_i,
  input  wire  dmiss_pkg::miss_op_t          miss_op_i,
  output logic                               mem_req_valid_o,
  input  wire                                mem_req_ready_i,
  output logic [dmiss_pkg::LINE_ADDR_W-1:0]  mem_req_addr_o,
  output dmiss_pkg::miss_op_t                mem_req_op_o,
  output logic [dmiss_pkg::TAG_W-1:0]        mem_req_tag_o,
  input  wire                                mem_rsp_valid_i,
  input  wire  [dmiss_pkg::TAG_W-1:0]        mem_rsp_tag_i,
  output logic                               locked_o,
  output logic                               replay_o
);

  logic                                              alloc_valid;
  logic                                              alloc_ready;
  logic [dmiss_pkg::LINE_ADDR_W-1:0]                 alloc_addr;
  dmiss_pkg::miss_op_t                               alloc_op;
  logic [NUM_ENTRIES-1:0]                            pending_vec;
  logic [NUM_ENTRIES-1:0]                            issued_vec;  // also seen by the checker
  logic [NUM_ENTRIES-1:0][dmiss_pkg::LINE_ADDR_W-1:0] entry_addr;
  dmiss_pkg::miss_op_t [NUM_ENTRIES-1:0]             entry_op;
  logic                                              issue_en;
  logic [dmiss_pkg::TAG_W-1:0]                       issue_tag;
  logic                                              done_en;
  logic [dmiss_pkg::TAG_W-1:0]                       done_tag;

  miss_intake u_intake (
    .clk           (clk),
    .rst           (rst),
    .miss_valid_i  (miss_valid_i),
    .miss_ready_o  (miss_ready_o),
    .miss_addr_i   (miss_addr_i),
    .miss_op_i     (miss_op_i),
    .alloc_valid_o (alloc_valid),
    .alloc_ready_i (alloc_ready),
    .alloc_addr_o  (alloc_addr),
    .alloc_op_o    (alloc_op)
  );

  miss_cam #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) u_cam (
    .clk           (clk),
    .rst           (rst),
    .alloc_valid_i (alloc_valid),
    .alloc_ready_o (alloc_ready),
    .alloc_addr_i  (alloc_addr),
    .alloc_op_i    (alloc_op),
    .issue_en_i    (issue_en),
    .issue_tag_i   (issue_tag),
    .done_en_i     (done_en),
    .done_tag_i    (done_tag),
    .pending_vec_o (pending_vec),
    .issued_vec_o  (issued_vec),
    .entry_addr_o  (entry_addr),
    .entry_op_o    (entry_op),
    .locked_o      (locked_o),
    .replay_o      (replay_o)
  );

  refill_sequencer #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) u_seq (
    .clk             (clk),
    .rst             (rst),
    .pending_vec_i   (pending_vec),
    .entry_addr_i    (entry_addr),
    .entry_op_i      (entry_op),
    .issue_en_o      (issue_en),
    .issue_tag_o     (issue_tag),
    .done_en_o       (done_en),
    .done_tag_o      (done_tag),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_op_o    (mem_req_op_o),
    .mem_req_tag_o   (mem_req_tag_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_tag_i   (mem_rsp_tag_i)
  );

endmodule

`default_nettype wire

//--- verif/dmiss_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dmiss_checker #(
  parameter int NUM_ENTRIES = 16
) (
  input wire                               clk,
  input wire                               rst,
  input wire                               mem_req_valid_i,
  input wire                               mem_req_ready_i,
  input wire [dmiss_pkg::LINE_ADDR_W-1:0]  mem_req_addr_i,
  input wire                               mem_req_op_i,
  input wire [dmiss_pkg::TAG_W-1:0]        mem_req_tag_i,
  input wire                               replay_i,
  input wire                               locked_i,
  input wire                               slot_full_i,
  input wire                               miss_ready_i,
  input wire [NUM_ENTRIES-1:0]             issued_vec_i
);

  req_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_addr_i)
      && $stable(mem_req_op_i) && $stable(mem_req_tag_i))
    else $error("memory request changed while stalled");

  replay_one_cycle: assert property (@(posedge clk) disable iff (rst) replay_i |=> !replay_i)
    else $error("replay held longer than one cycle");

  locked_blocks: assert property (@(posedge clk) disable iff (rst)
    locked_i && slot_full_i |-> !miss_ready_i)
    else $error("miss accepted while locked with a full slot");

  tag_issued: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid_i |-> issued_vec_i[mem_req_tag_i])
    else $error("request tag names an entry that is not issued");

endmodule

bind dmiss_top dmiss_checker #(.NUM_ENTRIES(NUM_ENTRIES)) u_checker (
  .clk(clk), .rst(rst),
  .mem_req_valid_i(mem_req_valid_o), .mem_req_ready_i(mem_req_ready_i),
  .mem_req_addr_i(mem_req_addr_o), .mem_req_op_i(mem_req_op_o),
  .mem_req_tag_i(mem_req_tag_o), .replay_i(replay_o), .locked_i(locked_o),
  .slot_full_i(alloc_valid), .miss_ready_i(miss_ready_o), .issued_vec_i(issued_vec)
);

`default_nettype wire

//--- verif/dmiss_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dmiss_tb;

  localparam int NUM_ENTRIES = 16;
  localparam int AW = dmiss_pkg::LINE_ADDR_W;
  localparam int TW = dmiss_pkg::TAG_W;
  // rough per-test cycle budgets summed plus margin
  localparam int CYCLE_LIMIT = 60 + 40 + 160 + 200 + 3 * 90 + 500;

  logic clk;
  logic rst;
  logic miss_valid_i;
  logic [AW-1:0] miss_addr_i;
  dmiss_pkg::miss_op_t miss_op_i;
  logic mem_req_ready_i;
  logic mem_rsp_valid_i;
  logic [TW-1:0] mem_rsp_tag_i;
  logic miss_ready_o;
  logic mem_req_valid_o;
  logic [AW-1:0] mem_req_addr_o;
  dmiss_pkg::miss_op_t mem_req_op_o;
  logic [TW-1:0] mem_req_tag_o;
  logic locked_o;
  logic replay_o;

  logic [31:0] lfsr;
  int errors;
  int checks;
  int cycles;
  int replay_cnt;
  bit stall_en;
  logic [TW-1:0] req_tag [$];
  logic [AW-1:0] req_addr [$];
  dmiss_pkg::miss_op_t req_op [$];
  logic [TW-1:0] open_tags [$];  // requested but not yet answered

  dmiss_top #(.NUM_ENTRIES(NUM_ENTRIES)) DUT (
    .clk(clk), .rst(rst),
    .miss_valid_i(miss_valid_i), .miss_ready_o(miss_ready_o),
    .miss_addr_i(miss_addr_i), .miss_op_i(miss_op_i),
    .mem_req_valid_o(mem_req_valid_o), .mem_req_ready_i(mem_req_ready_i),
    .mem_req_addr_o(mem_req_addr_o), .mem_req_op_o(mem_req_op_o),
    .mem_req_tag_o(mem_req_tag_o),
    .mem_rsp_valid_i(mem_rsp_valid_i), .mem_rsp_tag_i(mem_rsp_tag_i),
    .locked_o(locked_o), .replay_o(replay_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // memory side monitor and watchdog
  always @(posedge clk) begin
    cycles++;
    if (!rst && mem_req_valid_o && mem_req_ready_i) begin
      req_tag.push_back(mem_req_tag_o);
      req_addr.push_back(mem_req_addr_o);
      req_op.push_back(mem_req_op_o);
      open_tags.push_back(mem_req_tag_o);
    end
    if (!rst && replay_o) replay_cnt++;
    if (cycles > CYCLE_LIMIT) begin
      $display("run exceeded %0d cycles, a test stopped making progress", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (stall_en) mem_req_ready_i = |(rand_bits(1) | rand_bits(1));  // ~75% ready
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // every task starts and ends just after a falling edge
  task automatic send_miss(input logic [AW-1:0] addr, input dmiss_pkg::miss_op_t op);
    miss_valid_i = 1'b1;
    miss_addr_i  = addr;
    miss_op_i    = op;
    do @(posedge clk); while (!miss_ready_o);
    @(negedge clk);
    miss_valid_i = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_reqs(input int n);
    while (req_tag.size() < n) @(negedge clk);
  endtask

  task automatic respond(input logic [TW-1:0] tag);
    foreach (open_tags[i]) begin
      if (open_tags[i] == tag) begin
        open_tags.delete(i);
        break;
      end
    end
    mem_rsp_valid_i = 1'b1;
    mem_rsp_tag_i   = tag;
    @(negedge clk);
    mem_rsp_valid_i = 1'b0;
  endtask

  task automatic finish_epoch();
    int r0;
    r0 = replay_cnt;
    while (open_tags.size() > 0) respond(open_tags[0]);
    while (replay_cnt == r0) @(negedge clk);
  endtask

  task automatic new_test();
    req_tag.delete();
    req_addr.delete();
    req_op.delete();
  endtask

  task automatic report(input string name, input int e0);
    $display("%s: %s (%0d errors)", name, (errors == e0) ? "ok" : "failed", errors - e0);
  endtask

  task automatic single_load_replay();
    int e0;
    int r0;
    e0 = errors;
    new_test();
    r0 = replay_cnt;
    send_miss(37'h0_1234_5678, dmiss_pkg::MISS_LOAD);
    wait_reqs(1);
    check("mem_req_addr_o", req_addr[0], 37'h0_1234_5678);
    check("mem_req_op_o", req_op[0], dmiss_pkg::MISS_LOAD);
    check("mem_req_tag_o", req_tag[0], 0);
    respond(req_tag[0]);
    while (replay_cnt == r0) @(negedge clk);
    idle(5);
    check("replay_o pulses", replay_cnt - r0, 1);
    check("request count", req_tag.size(), 1);
    send_miss(37'h1_0000_0040, dmiss_pkg::MISS_LOAD);
    wait_reqs(2);
    check("mem_req_addr_o", req_addr[1], 37'h1_0000_0040);
    check("mem_req_tag_o", req_tag[1], 0);
    finish_epoch();
    report("single_load", e0);
  endtask

  task automatic merge_to_store();
    int e0;
    e0 = errors;
    new_test();
    send_miss(37'h0_00ab_cd00, dmiss_pkg::MISS_LOAD);
    send_miss(37'h0_00ab_cd00, dmiss_pkg::MISS_STORE);
    send_miss(37'h0_00ab_cd00, dmiss_pkg::MISS_LOAD);
    wait_reqs(1);
    idle(6);
    check("request count", req_tag.size(), 1);
    check("mem_req_op_o", req_op[0], dmiss_pkg::MISS_STORE);
    finish_epoch();
    report("merge", e0);
  endtask

  task automatic fill_until_locked();
    int e0;
    int r0;
    e0 = errors;
    new_test();
    for (int i = 0; i < NUM_ENTRIES; i++) send_miss(AW'(64'h200 + i), dmiss_pkg::MISS_LOAD);
    send_miss(37'h0_0000_0fff, dmiss_pkg::MISS_STORE);  // parks in the intake slot
    idle(4);
    wait_reqs(NUM_ENTRIES);
    idle(2);
    check("locked_o", locked_o, 1);
    check("miss_ready_o", miss_ready_o, 0);
    check("request count", req_tag.size(), NUM_ENTRIES);
    foreach (req_tag[i]) check("mem_req_tag_o", req_tag[i], i);
    r0 = replay_cnt;
    for (int t = NUM_ENTRIES - 1; t >= 0; t--) begin
      respond(TW'(t));
      if (t > 0) check("replay before last response", replay_cnt - r0, 0);
    end
    while (replay_cnt == r0) @(negedge clk);
    wait_reqs(NUM_ENTRIES + 1);
    check("replay_o pulses", replay_cnt - r0, 1);
    check("mem_req_addr_o", req_addr[NUM_ENTRIES], 37'h0_0000_0fff);
    check("mem_req_tag_o", req_tag[NUM_ENTRIES], 0);
    finish_epoch();
    report("fill_lock", e0);
  endtask

  task automatic issue_under_stall();
    int e0;
    int hits;
    logic [AW-1:0] sent [8];
    dmiss_pkg::miss_op_t sent_op [8];
    bit seen [NUM_ENTRIES];
    e0 = errors;
    new_test();
    foreach (sent[i]) begin
      sent[i]    = {rand_bits(32), 5'(i)};  // low bits keep them distinct
      sent_op[i] = dmiss_pkg::miss_op_t'(rand_bits(1));
    end
    @(posedge clk);
    stall_en = 1'b1;
    @(negedge clk);
    foreach (sent[i]) send_miss(sent[i], sent_op[i]);
    wait_reqs(8);
    @(posedge clk);
    stall_en = 1'b0;
    @(negedge clk);
    mem_req_ready_i = 1'b1;
    idle(6);
    check("request count", req_tag.size(), 8);
    foreach (sent[j]) begin
      hits = 0;
      foreach (req_addr[i]) begin
        if (req_addr[i] == sent[j]) begin
          hits++;
          check("mem_req_op_o", req_op[i], sent_op[j]);
        end
      end
      check("requests per sent line", hits, 1);
    end
    foreach (req_tag[i]) begin
      check("mem_req_tag_o unique", seen[req_tag[i]], 0);
      seen[req_tag[i]] = 1'b1;
    end
    finish_epoch();
    report("stall", e0);
  endtask

  task automatic epochs_of_misses();
    int e0;
    int r0;
    int idx;
    int n_lines;
    logic [AW-1:0] pool [6];
    bit used [6];
    bit store [6];
    bit hit;
    dmiss_pkg::miss_op_t op;
    e0 = errors;
    r0 = replay_cnt;
    foreach (pool[i]) pool[i] = AW'(64'h7_0000_0000 + 64'h40 * i);
    for (int ep = 0; ep < 3; ep++) begin
      new_test();
      used  = '{default: 1'b0};
      store = '{default: 1'b0};
      mem_req_ready_i = 1'b0;  // hold issue so late stores still merge before the request
      for (int m = 0; m < 10; m++) begin
        idx = rand_bits(3) % 6;
        // first request loads at once so it opens as a store
        op = (m == 0) ? dmiss_pkg::MISS_STORE : dmiss_pkg::miss_op_t'(rand_bits(1));
        used[idx]  = 1'b1;
        store[idx] = store[idx] | (op == dmiss_pkg::MISS_STORE);
        send_miss(pool[idx], op);
      end
      idle(3);
      mem_req_ready_i = 1'b1;
      n_lines = 0;
      foreach (used[i]) n_lines += used[i];
      wait_reqs(n_lines);
      idle(4);
      check("request count", req_tag.size(), n_lines);
      foreach (pool[i]) begin
        hit = 1'b0;
        foreach (req_addr[j]) begin
          if (req_addr[j] == pool[i]) begin
            check("duplicate request", hit, 0);
            check("mem_req_op_o", req_op[j], store[i]);
            hit = 1'b1;
          end
        end
        check("line requested", hit, used[i]);
      end
      finish_epoch();
    end
    check("replay count", replay_cnt - r0, 3);
    report("epochs", e0);
  endtask

  initial begin
    lfsr = 32'hb69a_d49a;
    rst = 1'b1;
    miss_valid_i = 1'b0;
    miss_addr_i = '0;
    miss_op_i = dmiss_pkg::MISS_LOAD;
    mem_req_ready_i = 1'b1;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_tag_i = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check("miss_ready_o", miss_ready_o, 1);
    check("mem_req_valid_o", mem_req_valid_o, 0);
    check("locked_o", locked_o, 0);
    check("replay_o", replay_o, 0);
    single_load_replay();
    merge_to_store();
    fill_until_locked();
    issue_under_stall();
    epochs_of_misses();
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
hw/dmiss_pkg.sv
hw/miss_entry.sv
hw/miss_cam.sv
hw/miss_intake.sv
hw/refill_sequencer.sv
hw/dmiss_top.sv
verif/dmiss_checker.sv
verif/dmiss_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= dmiss_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
